/* logic/dsp_pkg.sv */
// word types and post-adder operand selects shared by the slice.
// imported by every block that carries slice data.
`default_nettype none

package dsp_pkg;

   ////////////////////
   // word widths
   ////////////////////
   localparam int a_width      = 30;
   localparam int d_width      = 25;
   localparam int b_width      = 18;
   localparam int inmode_width = 5;
   localparam int p_width      = 48;

   typedef logic [a_width-1:0]      a_word;      // a operand and a cascade.
   typedef logic [d_width-1:0]      d_word;      // d, pre-adder and mult a side.
   typedef logic [b_width-1:0]      b_word;      // b operand and b cascade.
   typedef logic [p_width-1:0]      p_word;      // product, c and p.

   // bit 0 picks a1 over a2, bit 1 zeroes a, bit 2 enables d, bit 3 subtracts a.
   typedef logic [inmode_width-1:0] inmode_word;

   ////////////////////
   // post-adder selects
   ////////////////////
   // encodings follow the low opmode bits of the full slice.
   typedef enum logic [1:0] {
      x_zero = 2'b00,
      x_mult = 2'b01,
      x_ab   = 2'b11
   } x_sel_t;

   typedef enum logic [1:0] {
      z_zero = 2'b00,
      z_p    = 2'b10,
      z_c    = 2'b11
   } z_sel_t;

endpackage

`default_nettype wire

/* logic/pipe_reg.sv */
// clock-enabled register chain of depth 0, 1 or 2 with synchronous reset.
// first taps stage one for cascades; depth 0 is a plain bypass.
`default_nettype none

module pipe_reg #(
   parameter int width = 48,
   parameter int depth = 1
) (
   input  wire                                clk,
   input  wire                                reset,
   input  wire [((depth > 0) ? depth : 1)-1:0] ce,
   input  wire [width-1:0]                    din,
   output logic [width-1:0]                   first,
   output logic [width-1:0]                   dout
);

   generate
      if (depth == 0) begin : g_bypass
         assign first = din;
         assign dout  = din;
      end else begin : g_regs
         logic [depth-1:0][width-1:0] stage;

         always_ff @(posedge clk) begin
            if (reset) stage[0] <= '0;
            else if (ce[0]) stage[0] <= din;
         end

         for (genvar i = 1; i < depth; i++) begin : g_stage
            always_ff @(posedge clk) begin
               if (reset) stage[i] <= '0;
               else if (ce[i]) stage[i] <= stage[i-1]; // each stage has its own enable.
            end
         end

         assign first = stage[0];
         assign dout  = stage[depth-1];
      end
   endgenerate

endmodule

`default_nettype wire

/* logic/dual_ad_preadder.sv */
// a/d input registers, 25-bit pre-adder and ad register feeding the multiplier.
// also produces the a cascade and the a word for the wide x operand.
`default_nettype none

module dual_ad_preadder import dsp_pkg::*; #(
   parameter int a_cascade = 0,   // 1 takes acin instead of a.
   parameter int areg      = 1,
   parameter int acascreg  = 1,
   parameter int dreg      = 1,
   parameter int adreg     = 1,
   parameter int use_dport = 1
) (
   input  wire        clk,
   input  wire        reset,
   input  wire a_word      a,
   input  wire a_word      acin,
   input  wire d_word      d,
   input  wire inmode_word inmode,
   input  wire        ce_a1,
   input  wire        ce_a2,
   input  wire        ce_d,
   input  wire        ce_ad,
   output a_word      acout,
   output a_word      xmux_a,
   output d_word      amult
);

   a_word a_in;
   a_word a1_out;
   d_word d_out;
   d_word a_cand;
   d_word adder_a;
   d_word adder_d;
   d_word adder_out;
   d_word ad_out;

   ////////////////////
   // a input chain
   ////////////////////
   assign a_in = (a_cascade == 1) ? acin : a;

   // a1 only sits in the path for a two-deep chain.
   pipe_reg #(
      .width($bits(a_word)),
      .depth((areg == 2) ? 1 : 0)
   ) u_a1 (
      .clk  (clk),
      .reset(reset),
      .ce   (ce_a1),
      .din  (a_in),
      .first(),
      .dout (a1_out)
   );

   pipe_reg #(
      .width($bits(a_word)),
      .depth((areg > 0) ? 1 : 0)
   ) u_a2 (
      .clk  (clk),
      .reset(reset),
      .ce   (ce_a2),
      .din  (a1_out),
      .first(),
      .dout (xmux_a)
   );

   assign acout = (acascreg == 1 && areg == 2) ? a1_out : xmux_a;

   ////////////////////
   // d register and pre-adder
   ////////////////////
   pipe_reg #(
      .width($bits(d_word)),
      .depth(dreg)
   ) u_d (
      .clk  (clk),
      .reset(reset),
      .ce   (ce_d),
      .din  (d),
      .first(),
      .dout (d_out)
   );

   assign a_cand    = inmode[0] ? a1_out[24:0] : xmux_a[24:0];
   assign adder_a   = inmode[1] ? '0 : a_cand;
   assign adder_d   = inmode[2] ? d_out : '0;
   assign adder_out = inmode[3] ? (adder_d - adder_a) : (adder_d + adder_a); // wraps at 25 bits.

   pipe_reg #(
      .width($bits(d_word)),
      .depth(adreg)
   ) u_ad (
      .clk  (clk),
      .reset(reset),
      .ce   (ce_ad),
      .din  (adder_out),
      .first(),
      .dout (ad_out)
   );

   // without the d port the multiplier sees the a chain directly.
   assign amult = (use_dport == 1) ? ad_out : xmux_a[24:0];

endmodule

`default_nettype wire

/* logic/b_input_path.sv */
// b input select, b1/b2 registers and b cascade tap.
`default_nettype none

module b_input_path import dsp_pkg::*; #(
   parameter int b_cascade = 0,   // 1 takes bcin instead of b.
   parameter int breg      = 2,
   parameter int bcascreg  = 1
) (
   input  wire        clk,
   input  wire        reset,
   input  wire b_word b,
   input  wire b_word bcin,
   input  wire        ce_b1,
   input  wire        ce_b2,
   output b_word      bcout,
   output b_word      bmult
);

   localparam int ce_w = (breg > 0) ? breg : 1;

   b_word b_in;
   b_word b1_out;
   logic [1:0] b_ce;

   assign b_in = (b_cascade == 1) ? bcin : b;

   // a single stage is the b2 register, as on the a side.
   assign b_ce = (breg == 2) ? {ce_b2, ce_b1} : {ce_b2, ce_b2};

   pipe_reg #(
      .width($bits(b_word)),
      .depth(breg)
   ) u_b (
      .clk  (clk),
      .reset(reset),
      .ce   (b_ce[ce_w-1:0]),
      .din  (b_in),
      .first(b1_out),
      .dout (bmult)
   );

   ////////////////////
   // cascade tap
   ////////////////////
   assign bcout = (bcascreg == 1 && breg == 2) ? b1_out : bmult; // b1 tap only when two deep.

endmodule

`default_nettype wire

/* logic/mult_stage.sv */
// signed 25x18 multiplier, sign extended to 48 bits, optional m register.
`default_nettype none

module mult_stage import dsp_pkg::*; #(
   parameter int mreg = 1
) (
   input  wire        clk,
   input  wire        reset,
   input  wire        ce_m,
   input  wire d_word amult,
   input  wire b_word bmult,
   output p_word      m
);

   p_word a_ext;
   p_word b_ext;
   p_word product;

   ////////////////////
   // multiply
   ////////////////////
   // widen both sides first so the low 48 bits are the signed product.
   assign a_ext = {{($bits(p_word) - $bits(d_word)){amult[$bits(d_word)-1]}}, amult};
   assign b_ext = {{($bits(p_word) - $bits(b_word)){bmult[$bits(b_word)-1]}}, bmult};

   assign product = a_ext * b_ext; // 43 significant bits.

   pipe_reg #(
      .width($bits(p_word)),
      .depth(mreg)
   ) u_m (
      .clk  (clk),
      .reset(reset),
      .ce   (ce_m),
      .din  (product),
      .first(),
      .dout (m)
   );

endmodule

`default_nettype wire

/* logic/alu_accum.sv */
// 48-bit post-adder with x/z operand muxes and the p register.
// z_p feeds p back for accumulation.
`default_nettype none

module alu_accum import dsp_pkg::*; #(
   parameter int preg = 1
) (
   input  wire         clk,
   input  wire         reset,
   input  wire         ce_p,
   input  wire p_word  m,
   input  wire p_word  c,
   input  wire a_word  xmux_a,
   input  wire b_word  bmult,
   input  wire x_sel_t x_sel,
   input  wire z_sel_t z_sel,
   input  wire         alu_sub,
   output p_word       p
);

   p_word x_mux;
   p_word z_mux;
   p_word ab_word;
   p_word alu_out;

   assign ab_word = {xmux_a, bmult}; // a:b concatenation.

   ////////////////////
   // operand select
   ////////////////////
   always_comb begin
      case (x_sel)
         x_mult:  x_mux = m;
         x_ab:    x_mux = ab_word;
         default: x_mux = '0;
      endcase
   end

   always_comb begin
      case (z_sel)
         z_p:     z_mux = p;
         z_c:     z_mux = c;
         default: z_mux = '0;
      endcase
   end

   // z minus x, not x minus z.
   assign alu_out = alu_sub ? (z_mux - x_mux) : (z_mux + x_mux);

   ////////////////////
   // p register
   ////////////////////
   pipe_reg #(
      .width($bits(p_word)),
      .depth(preg)
   ) u_p (
      .clk  (clk),
      .reset(reset),
      .ce   (ce_p),
      .din  (alu_out),
      .first(),
      .dout (p)
   );

endmodule

`default_nettype wire

/* logic/dsp_slice.sv */
// top of the multiply-accumulate slice; wires pre-adder, b path,
// multiplier and post-adder together and hands down the register options.
`default_nettype none

module dsp_slice import dsp_pkg::*; #(
   parameter int a_cascade = 0,
   parameter int areg      = 1,
   parameter int acascreg  = 1,
   parameter int dreg      = 1,
   parameter int adreg     = 1,
   parameter int use_dport = 1,
   parameter int b_cascade = 0,
   parameter int breg      = 2,
   parameter int bcascreg  = 1,
   parameter int mreg      = 1,
   parameter int preg      = 1
) (
   input  wire             clk,
   input  wire             reset,
   input  wire a_word      a,
   input  wire a_word      acin,
   input  wire d_word      d,
   input  wire b_word      b,
   input  wire b_word      bcin,
   input  wire p_word      c,
   input  wire inmode_word inmode,
   input  wire x_sel_t     x_sel,
   input  wire z_sel_t     z_sel,
   input  wire             alu_sub,
   input  wire             ce_a1,
   input  wire             ce_a2,
   input  wire             ce_d,
   input  wire             ce_ad,
   input  wire             ce_b1,
   input  wire             ce_b2,
   input  wire             ce_m,
   input  wire             ce_p,
   output p_word           p,
   output a_word           acout,
   output b_word           bcout
);

   d_word amult;
   a_word xmux_a;
   b_word bmult;
   p_word m;

   dual_ad_preadder #(
      .a_cascade(a_cascade),
      .areg     (areg),
      .acascreg (acascreg),
      .dreg     (dreg),
      .adreg    (adreg),
      .use_dport(use_dport)
   ) u_preadder (
      .clk   (clk),
      .reset (reset),
      .a     (a),
      .acin  (acin),
      .d     (d),
      .inmode(inmode),
      .ce_a1 (ce_a1),
      .ce_a2 (ce_a2),
      .ce_d  (ce_d),
      .ce_ad (ce_ad),
      .acout (acout),
      .xmux_a(xmux_a),
      .amult (amult)
   );

   b_input_path #(
      .b_cascade(b_cascade),
      .breg     (breg),
      .bcascreg (bcascreg)
   ) u_bpath (
      .clk  (clk),
      .reset(reset),
      .b    (b),
      .bcin (bcin),
      .ce_b1(ce_b1),
      .ce_b2(ce_b2),
      .bcout(bcout),
      .bmult(bmult)
   );

   mult_stage #(
      .mreg(mreg)
   ) u_mult (
      .clk  (clk),
      .reset(reset),
      .ce_m (ce_m),
      .amult(amult),
      .bmult(bmult),
      .m    (m)
   );

   alu_accum #(
      .preg(preg)
   ) u_alu (
      .clk    (clk),
      .reset  (reset),
      .ce_p   (ce_p),
      .m      (m),
      .c      (c),
      .xmux_a (xmux_a),
      .bmult  (bmult),
      .x_sel  (x_sel),
      .z_sel  (z_sel),
      .alu_sub(alu_sub),
      .p      (p)
   );

endmodule

`default_nettype wire

/* test/dsp_slice_props.sv */
// concurrent checks on reset, p hold and cascade timing.
// bound into every dsp_slice instance.
`default_nettype none

module dsp_slice_props import dsp_pkg::*; (
   input wire        clk,
   input wire        reset,
   input wire a_word a,
   input wire b_word b,
   input wire        ce_a2,
   input wire        ce_b1,
   input wire        ce_p,
   input wire p_word p,
   input wire a_word acout,
   input wire b_word bcout
);

   ////////////////////
   // reset and hold
   ////////////////////
   p_clear_after_reset: assert property (@(posedge clk) reset |=> (p == '0))
      else $error("p not zero after a reset cycle");

   p_hold_when_disabled: assert property (
      @(posedge clk) disable iff (reset) !ce_p |=> $stable(p))
      else $error("p changed while its enable was low");

   ////////////////////
   // cascade alignment
   ////////////////////
   // with areg at 1 the a2 stage drives acout.
   acout_follows_a: assert property (
      @(posedge clk) disable iff (reset) ce_a2 |=> (acout == $past(a)))
      else $error("acout does not match a from the previous cycle");

   bcout_follows_b: assert property (
      @(posedge clk) disable iff (reset) ce_b1 |=> (bcout == $past(b))) // b1 tap.
      else $error("bcout does not match b from the previous cycle");

endmodule

bind dsp_slice dsp_slice_props u_props (
   .clk  (clk),
   .reset(reset),
   .a    (a),
   .b    (b),
   .ce_a2(ce_a2),
   .ce_b1(ce_b1),
   .ce_p (ce_p),
   .p    (p),
   .acout(acout),
   .bcout(bcout)
);

`default_nettype wire

/* test/dsp_slice_tb.sv */
// directed testbench for the slice in its default build.
// covers pre-adder modes, accumulation, wide path, cascades, hold and reset.
`default_nettype none

module dsp_slice_tb import dsp_pkg::*; ();

   localparam int p_lat           = 4;    // inputs to p, every enable high.
   localparam int n_ops           = 8;
   localparam int watchdog_cycles = 1000;

   logic       clk;
   logic       reset;
   a_word      a;
   a_word      acin;
   d_word      d;
   b_word      b;
   b_word      bcin;
   p_word      c;
   inmode_word inmode;
   x_sel_t     x_sel;
   z_sel_t     z_sel;
   logic       alu_sub;
   logic [7:0] ce;       // {p, m, b2, b1, ad, d, a2, a1}.
   p_word      p;
   a_word      acout;
   b_word      bcout;

   int checks;
   int errors;
   int tests;
   int failed_tests;

   dsp_slice dut (
      .clk    (clk),
      .reset  (reset),
      .a      (a),
      .acin   (acin),
      .d      (d),
      .b      (b),
      .bcin   (bcin),
      .c      (c),
      .inmode (inmode),
      .x_sel  (x_sel),
      .z_sel  (z_sel),
      .alu_sub(alu_sub),
      .ce_a1  (ce[0]),
      .ce_a2  (ce[1]),
      .ce_d   (ce[2]),
      .ce_ad  (ce[3]),
      .ce_b1  (ce[4]),
      .ce_b2  (ce[5]),
      .ce_m   (ce[6]),
      .ce_p   (ce[7]),
      .p      (p),
      .acout  (acout),
      .bcout  (bcout)
   );

   always #20 clk = ~clk;

   initial begin
      for (int n = 0; n < watchdog_cycles; n++) @(posedge clk);
      $display("timeout: the tests did not finish in %0d cycles", watchdog_cycles);
      $display(">>> FAIL");
      $finish;
   end

   ////////////////////
   // helpers and model
   ////////////////////
   task automatic tick();
      @(posedge clk);
      #2;   // drive just after the edge.
   endtask

   task automatic check_value(string name, p_word expected, p_word actual);
      checks++;
      assert (actual === expected) else begin
         $display("FAIL %s: expected %h, actual %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic report(string name, int errors_before);
      tests++;
      if (errors == errors_before) begin
         $display("test %s: ok", name);
      end else begin
         failed_tests++;
         $display("test %s: %0d errors", name, errors - errors_before);
      end
   endtask

   // d term plus or minus the low 25 bits of a, wrapping at 25 bits.
   function automatic d_word preadd_model(d_word dv, a_word av, inmode_word inm);
      d_word d_term;
      d_word a_term;
      d_term = inm[2] ? dv : '0;
      a_term = inm[1] ? '0 : av[24:0];
      return inm[3] ? (d_term - a_term) : (d_term + a_term);
   endfunction

   function automatic p_word mult_model(d_word ad, b_word bv);
      longint sa;
      longint sb;
      longint prod;
      sa   = longint'($signed(ad));
      sb   = longint'($signed(bv));
      prod = sa * sb;
      return prod[47:0];
   endfunction

   task automatic random_operands();
      a = a_word'($urandom());
      d = d_word'($urandom());
      b = b_word'($urandom());
      c = p_word'({$urandom(), $urandom()});
   endtask

   // zero operands until m and p read zero.
   task automatic flush();
      a       = '0;
      d       = '0;
      b       = '0;
      x_sel   = x_mult;
      z_sel   = z_zero;
      alu_sub = 1'b0;
      for (int i = 0; i < p_lat; i++) tick();
   endtask

   ////////////////////
   // tests
   ////////////////////
   // the edge that samples an operand is the first of the p_lat edges.
   task automatic product_test(string name, inmode_word inm);
      p_word expected[n_ops];
      int    errors_before;
      errors_before = errors;
      inmode  = inm;
      x_sel   = x_mult;
      z_sel   = z_zero;
      alu_sub = 1'b0;
      for (int i = 0; i < n_ops + p_lat - 1; i++) begin
         if (i < n_ops) begin
            random_operands();
            expected[i] = mult_model(preadd_model(d, a, inm), b);
         end
         tick();
         if (i >= p_lat - 1) check_value(name, expected[i - p_lat + 1], p);
      end
      report(name, errors_before);
   endtask

   task automatic accumulate_test(string name, logic sub);
      p_word results[n_ops];
      p_word acc;
      int    errors_before;
      errors_before = errors;
      flush();
      inmode  = 5'b00100;
      z_sel   = z_p;
      alu_sub = sub;
      acc     = '0;
      for (int i = 0; i < n_ops + p_lat - 1; i++) begin
         if (i < n_ops) begin
            random_operands();
            results[i] = mult_model(preadd_model(d, a, inmode), b);
         end else begin
            a = '0;
            d = '0;
            b = '0;
         end
         tick();
         if (i >= p_lat - 1) begin
            acc = sub ? acc - results[i - p_lat + 1] : acc + results[i - p_lat + 1];
         end
         check_value(name, acc, p);
      end
      report(name, errors_before);
   endtask

   // a reaches x_ab one edge after sampling, b two edges after.
   task automatic wide_test(string name, logic sub);
      a_word a_hist[n_ops];
      b_word b_hist[n_ops];
      p_word ab;
      int    errors_before;
      errors_before = errors;
      x_sel   = x_ab;
      z_sel   = z_c;
      alu_sub = sub;
      for (int i = 0; i < n_ops; i++) begin
         random_operands();
         a_hist[i] = a;
         b_hist[i] = b;
         tick();
         if (i >= 2) begin
            ab = {a_hist[i-1], b_hist[i-2]};
            check_value(name, sub ? c - ab : c + ab, p);
         end
      end
      report(name, errors_before);
   endtask

   task automatic cascade_test(string name);
      int errors_before;
      errors_before = errors;
      for (int i = 0; i < n_ops; i++) begin
         random_operands();
         tick();
         check_value({name, " acout"}, p_word'(a), p_word'(acout));
         check_value({name, " bcout"}, p_word'(b), p_word'(bcout));
      end
      report(name, errors_before);
   endtask

   task automatic hold_test(string name);
      p_word held;
      int    errors_before;
      errors_before = errors;
      x_sel = x_ab;
      z_sel = z_c;
      held  = p;
      ce[7] = 1'b0;
      for (int i = 0; i < n_ops; i++) begin
         random_operands();
         tick();
         check_value(name, held, p);
      end
      ce[7] = 1'b1;
      report(name, errors_before);
   endtask

   task automatic reset_test(string name);
      int errors_before;
      errors_before = errors;
      reset = 1'b1;
      for (int i = 0; i < 3; i++) begin
         random_operands();
         tick();
         check_value({name, " p"}, '0, p);
         check_value({name, " acout"}, '0, p_word'(acout));
         check_value({name, " bcout"}, '0, p_word'(bcout));
      end
      reset = 1'b0;
      report(name, errors_before);
   endtask

   initial begin
      void'($urandom(32'h809b8005));
      clk          = 1'b0;
      reset        = 1'b1;
      a            = '0;
      acin         = '0;
      d            = '0;
      b            = '0;
      bcin         = '0;
      c            = '0;
      inmode       = '0;
      x_sel        = x_zero;
      z_sel        = z_zero;
      alu_sub      = 1'b0;
      ce           = '1;
      checks       = 0;
      errors       = 0;
      tests        = 0;
      failed_tests = 0;
      for (int i = 0; i < 10; i++) tick();
      reset = 1'b0;

      product_test("preadd_sum", 5'b00100);
      product_test("preadd_minus_a", 5'b01100);
      product_test("preadd_d_only", 5'b00110);
      product_test("preadd_a_only", 5'b00000);
      accumulate_test("accum_add", 1'b0);
      accumulate_test("accum_sub", 1'b1);
      wide_test("wide_add", 1'b0);
      wide_test("wide_sub", 1'b1);
      cascade_test("cascade");
      hold_test("p_hold");
      reset_test("mid_reset");

      $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
               tests, failed_tests, checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
logic/dsp_pkg.sv
logic/pipe_reg.sv
logic/dual_ad_preadder.sv
logic/b_input_path.sv
logic/mult_stage.sv
logic/alu_accum.sv
logic/dsp_slice.sv
test/dsp_slice_props.sv
test/dsp_slice_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := dsp_slice_tb
FILELIST  := verilog.f
OBJDIR    := obj_dir
PASS_MSG  := >>> PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)
